/* verilog/ntt_bfly_pkg.sv */
package ntt_bfly_pkg;

    // ==================================================
    // Sizes and constants
    // ==================================================
    localparam int COEF_W       = 23;
    // ML-DSA prime, 2^23 - 2^13 + 1
    localparam logic [COEF_W-1:0] Q = 23'd8380417;
    localparam int NUM_LANES    = 4;
    localparam int LANE_CREDITS = 2;
    localparam int LANE_LAT     = 4;
    localparam int FIFO_DEPTH   = 8;
    localparam int BUS_W        = 72;

    // Register map
    localparam logic [1:0] ADDR_CTRL   = 2'd0;
    localparam logic [1:0] ADDR_JOB    = 2'd1;
    localparam logic [1:0] ADDR_RESULT = 2'd2;
    localparam logic [1:0] ADDR_STATUS = 2'd3;

    // ==================================================
    // Job and result types
    // ==================================================
    typedef enum logic {
        MODE_CT = 1'b0,
        MODE_GS = 1'b1
    } mode_t;

    typedef struct packed {
        mode_t             mode;
        logic [COEF_W-1:0] u;
        logic [COEF_W-1:0] v;
        logic [COEF_W-1:0] w;
    } bfly_job_t;

    typedef struct packed {
        logic [COEF_W-1:0] a;
        logic [COEF_W-1:0] b;
    } bfly_result_t;

    // ==================================================
    // Host port
    // ==================================================
    typedef struct packed {
        logic [BUS_W-2:0] rsvd;
        mode_t            mode;
    } ctrl_word_t;

    // u in the low slot, then v, then w; slot MSBs ignored
    typedef struct packed {
        logic              w_rsvd;
        logic [COEF_W-1:0] w;
        logic              v_rsvd;
        logic [COEF_W-1:0] v;
        logic              u_rsvd;
        logic [COEF_W-1:0] u;
    } operand_word_t;

    typedef union packed {
        ctrl_word_t    ctrl;
        operand_word_t op;
    } bus_word_u;

    typedef struct packed {
        logic       valid;
        logic       write;
        logic [1:0] addr;
        bus_word_u  wdata;
    } host_req_t;

    typedef struct packed {
        logic             ready;
        logic             rvalid;
        logic [BUS_W-1:0] rdata;
    } host_resp_t;

endpackage

/* verilog/ntt_mod_mult.sv */
`timescale 1ns/100ps

module ntt_mod_mult (
    input  logic                            hclk,
    input  logic                            rst_n_i,
    input  logic [ntt_bfly_pkg::COEF_W-1:0] a_i,
    input  logic [ntt_bfly_pkg::COEF_W-1:0] b_i,
    output logic [ntt_bfly_pkg::COEF_W-1:0] p_o
);

    logic [2*ntt_bfly_pkg::COEF_W-1:0] prod_q;
    logic [36:0] fold1;
    logic [27:0] fold2_q;
    logic [23:0] fold3;

    // ==================================================
    // Reduction using 2^23 = 2^13 - 1 (mod q)
    // ==================================================
    always_comb begin
        // hi * 2^23 + lo  ->  hi * (2^13 - 1) + lo, product below 2^46
        fold1 = {1'b0, prod_q[45:23], 13'd0} - 37'(prod_q[45:23]) + 37'(prod_q[22:0]);
        // Third fold leaves a value below 2q
        fold3 = {6'd0, fold2_q[27:23], 13'd0} - 24'(fold2_q[27:23]) + 24'(fold2_q[22:0]);
    end

    always_ff @(posedge hclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prod_q  <= '0;
            fold2_q <= '0;
            p_o     <= '0;
        end else begin
            // Stage 1 full product
            prod_q <= a_i * b_i;
            // Stage 2 second fold of the 37-bit value
            fold2_q <= {1'b0, fold1[36:23], 13'd0} - 28'(fold1[36:23]) + 28'(fold1[22:0]);
            // Stage 3 final correction
            if (fold3 >= 24'(ntt_bfly_pkg::Q)) begin
                p_o <= 23'(fold3 - 24'(ntt_bfly_pkg::Q));
            end else begin
                p_o <= fold3[22:0];
            end
        end
    end

endmodule

/* verilog/ntt_bfly_lane.sv */
`timescale 1ns/100ps

module ntt_bfly_lane (
    input  logic                       hclk,
    input  logic                       rst_n_i,
    input  logic                       issue_valid_i,
    input  ntt_bfly_pkg::bfly_job_t    job_i,
    output logic                       res_valid_o,
    output ntt_bfly_pkg::bfly_result_t res_o
);

    logic [ntt_bfly_pkg::LANE_LAT-1:0] vld_q;
    ntt_bfly_pkg::mode_t mode_q [ntt_bfly_pkg::LANE_LAT];
    logic [ntt_bfly_pkg::COEF_W-1:0] x_q [ntt_bfly_pkg::LANE_LAT];
    logic [ntt_bfly_pkg::COEF_W-1:0] mul_a_q, mul_b_q, prod, x_last;

    function automatic logic [ntt_bfly_pkg::COEF_W-1:0] add_mod(
        input logic [ntt_bfly_pkg::COEF_W-1:0] a,
        input logic [ntt_bfly_pkg::COEF_W-1:0] b
    );
        logic [ntt_bfly_pkg::COEF_W:0] s;
        s = {1'b0, a} + {1'b0, b};
        return (s >= ntt_bfly_pkg::Q) ? 23'(s - ntt_bfly_pkg::Q) : s[22:0];
    endfunction

    function automatic logic [ntt_bfly_pkg::COEF_W-1:0] sub_mod(
        input logic [ntt_bfly_pkg::COEF_W-1:0] a,
        input logic [ntt_bfly_pkg::COEF_W-1:0] b
    );
        return (a >= b) ? (a - b) : 23'(a + ntt_bfly_pkg::Q - b);
    endfunction

    // ==================================================
    // Front stage and side delay
    // ==================================================
    always_ff @(posedge hclk) begin
        if (job_i.mode == ntt_bfly_pkg::MODE_GS) begin
            // GS multiplies the difference
            x_q[0]  <= add_mod(job_i.u, job_i.v);
            mul_a_q <= sub_mod(job_i.u, job_i.v);
        end else begin
            x_q[0]  <= job_i.u;
            mul_a_q <= job_i.v;
        end
        mul_b_q   <= job_i.w;
        mode_q[0] <= job_i.mode;
        // Keep u or the sum aligned with the multiplier output
        for (int i = 1; i < ntt_bfly_pkg::LANE_LAT; i++) begin
            x_q[i]    <= x_q[i-1];
            mode_q[i] <= mode_q[i-1];
        end
    end

    always_ff @(posedge hclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[ntt_bfly_pkg::LANE_LAT-2:0], issue_valid_i};
        end
    end

    ntt_mod_mult ntt_mod_mult_inst (
        .hclk    (hclk),
        .rst_n_i (rst_n_i),
        .a_i     (mul_a_q),
        .b_i     (mul_b_q),
        .p_o     (prod)
    );

    // Output stage
    always_comb begin
        res_valid_o = vld_q[ntt_bfly_pkg::LANE_LAT-1];
        x_last      = x_q[ntt_bfly_pkg::LANE_LAT-1];
        if (mode_q[ntt_bfly_pkg::LANE_LAT-1] == ntt_bfly_pkg::MODE_CT) begin
            res_o.a = add_mod(x_last, prod);
            res_o.b = sub_mod(x_last, prod);
        end else begin
            res_o.a = x_last;
            res_o.b = prod;
        end
    end

endmodule

/* verilog/ntt_host_regs.sv */
`timescale 1ns/100ps

module ntt_host_regs (
    input  logic                       hclk,
    input  logic                       rst_n_i,
    input  ntt_bfly_pkg::host_req_t    host_req_i,
    output ntt_bfly_pkg::host_resp_t   host_resp_o,
    input  logic                       job_pop_i,
    output logic                       job_valid_o,
    output ntt_bfly_pkg::bfly_job_t    job_o,
    input  logic                       res_push_i,
    input  ntt_bfly_pkg::bfly_result_t res_i,
    output logic                       res_full_o,
    input  logic                       busy_i
);

    ntt_bfly_pkg::bfly_job_t    job_mem [ntt_bfly_pkg::FIFO_DEPTH];
    ntt_bfly_pkg::bfly_result_t res_mem [ntt_bfly_pkg::FIFO_DEPTH];
    logic [2:0] job_wr_q, job_rd_q, res_wr_q, res_rd_q;
    logic [3:0] job_cnt_q, res_cnt_q;
    ntt_bfly_pkg::mode_t mode_q;
    ntt_bfly_pkg::bfly_job_t new_job;
    ntt_bfly_pkg::bfly_result_t res_head;
    logic ready, accept, job_push, res_pop, busy, rvalid_q;
    logic [ntt_bfly_pkg::BUS_W-1:0] rdata_d, rdata_q;

    // ==================================================
    // Request decode
    // ==================================================
    always_comb begin
        // Only a job write into a full FIFO is held off
        ready = !(host_req_i.valid && host_req_i.write
                  && host_req_i.addr == ntt_bfly_pkg::ADDR_JOB
                  && job_cnt_q == 4'(ntt_bfly_pkg::FIFO_DEPTH));
        accept   = host_req_i.valid && ready;
        job_push = accept && host_req_i.write && host_req_i.addr == ntt_bfly_pkg::ADDR_JOB;
        res_pop  = accept && !host_req_i.write
                   && host_req_i.addr == ntt_bfly_pkg::ADDR_RESULT && res_cnt_q != 4'd0;

        new_job.mode = mode_q;
        new_job.u    = host_req_i.wdata.op.u;
        new_job.v    = host_req_i.wdata.op.v;
        new_job.w    = host_req_i.wdata.op.w;

        job_valid_o = (job_cnt_q != 4'd0);
        job_o       = job_mem[job_rd_q];
        res_full_o  = (res_cnt_q == 4'(ntt_bfly_pkg::FIFO_DEPTH));
        res_head    = res_mem[res_rd_q];
        busy        = busy_i || job_valid_o;

        case (host_req_i.addr)
            ntt_bfly_pkg::ADDR_CTRL:   rdata_d = {71'd0, mode_q};
            ntt_bfly_pkg::ADDR_RESULT: rdata_d = {res_cnt_q != 4'd0, 23'd0,
                                                  1'b0, res_head.b, 1'b0, res_head.a};
            ntt_bfly_pkg::ADDR_STATUS: rdata_d = {63'd0, busy, res_cnt_q, job_cnt_q};
            default:                   rdata_d = '0;
        endcase

        host_resp_o.ready  = ready;
        host_resp_o.rvalid = rvalid_q;
        host_resp_o.rdata  = rdata_q;
    end

    // ==================================================
    // Control state
    // ==================================================
    always_ff @(posedge hclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mode_q    <= ntt_bfly_pkg::MODE_CT;
            rvalid_q  <= 1'b0;
            job_wr_q  <= '0;
            job_rd_q  <= '0;
            job_cnt_q <= '0;
            res_wr_q  <= '0;
            res_rd_q  <= '0;
            res_cnt_q <= '0;
        end else begin
            rvalid_q <= accept && !host_req_i.write;
            if (accept && host_req_i.write && host_req_i.addr == ntt_bfly_pkg::ADDR_CTRL) begin
                mode_q <= host_req_i.wdata.ctrl.mode;
            end
            if (job_push) job_wr_q <= job_wr_q + 3'd1;
            if (job_pop_i) job_rd_q <= job_rd_q + 3'd1;
            job_cnt_q <= job_cnt_q + 4'(job_push) - 4'(job_pop_i);
            if (res_push_i) res_wr_q <= res_wr_q + 3'd1;
            if (res_pop) res_rd_q <= res_rd_q + 3'd1;
            res_cnt_q <= res_cnt_q + 4'(res_push_i) - 4'(res_pop);
        end
    end

    // FIFO storage and read data
    always_ff @(posedge hclk) begin
        if (job_push) job_mem[job_wr_q] <= new_job;
        if (res_push_i) res_mem[res_wr_q] <= res_i;
        if (accept && !host_req_i.write) rdata_q <= rdata_d;
    end

endmodule

/* verilog/ntt_job_dispatch.sv */
`timescale 1ns/100ps

module ntt_job_dispatch (
    input  logic                                 hclk,
    input  logic                                 rst_n_i,
    input  logic                                 job_valid_i,
    input  ntt_bfly_pkg::bfly_job_t              job_i,
    output logic                                 job_pop_o,
    output logic [ntt_bfly_pkg::NUM_LANES-1:0]   issue_valid_o,
    output ntt_bfly_pkg::bfly_job_t              issue_job_o,
    input  logic [ntt_bfly_pkg::NUM_LANES-1:0]   credit_return_i,
    output logic                                 busy_o
);

    logic [$clog2(ntt_bfly_pkg::NUM_LANES)-1:0] ptr_q;
    logic [1:0] credit_q [ntt_bfly_pkg::NUM_LANES];
    logic issue;

    // ==================================================
    // Issue decision
    // ==================================================
    always_comb begin
        // Strict lane order, so a lane out of credit stalls everything
        issue         = job_valid_i && (credit_q[ptr_q] != 2'd0);
        job_pop_o     = issue;
        issue_valid_o = issue ? (ntt_bfly_pkg::NUM_LANES'(1) << ptr_q) : '0;
        issue_job_o   = job_i;

        busy_o = 1'b0;
        for (int i = 0; i < ntt_bfly_pkg::NUM_LANES; i++) begin
            if (credit_q[i] != 2'(ntt_bfly_pkg::LANE_CREDITS)) begin
                busy_o = 1'b1;
            end
        end
    end

    // ==================================================
    // Pointer and credits
    // ==================================================
    always_ff @(posedge hclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr_q <= '0;
            for (int i = 0; i < ntt_bfly_pkg::NUM_LANES; i++) begin
                credit_q[i] <= 2'(ntt_bfly_pkg::LANE_CREDITS);
            end
        end else begin
            if (issue) ptr_q <= ptr_q + 1'b1;
            // Take and return may land on the same lane in one cycle
            for (int i = 0; i < ntt_bfly_pkg::NUM_LANES; i++) begin
                credit_q[i] <= credit_q[i] + 2'(credit_return_i[i]) - 2'(issue_valid_o[i]);
            end
        end
    end

endmodule

/* verilog/ntt_result_collect.sv */
`timescale 1ns/100ps

module ntt_result_collect (
    input  logic                               hclk,
    input  logic                               rst_n_i,
    input  logic [ntt_bfly_pkg::NUM_LANES-1:0] res_valid_i,
    input  ntt_bfly_pkg::bfly_result_t         res_i [ntt_bfly_pkg::NUM_LANES],
    input  logic                               res_full_i,
    output logic                               res_push_o,
    output ntt_bfly_pkg::bfly_result_t         res_o,
    output logic [ntt_bfly_pkg::NUM_LANES-1:0] credit_return_o
);

    // Two slots per lane, so one pointer bit each
    ntt_bfly_pkg::bfly_result_t slot_q [ntt_bfly_pkg::NUM_LANES][ntt_bfly_pkg::LANE_CREDITS];
    logic [ntt_bfly_pkg::NUM_LANES-1:0] wr_ptr_q;
    logic [ntt_bfly_pkg::NUM_LANES-1:0] rd_ptr_q;
    logic [1:0] cnt_q [ntt_bfly_pkg::NUM_LANES];
    logic [$clog2(ntt_bfly_pkg::NUM_LANES)-1:0] rr_q;

    // ==================================================
    // In-order drain
    // ==================================================
    always_comb begin
        res_push_o      = (cnt_q[rr_q] != 2'd0) && !res_full_i;
        res_o           = slot_q[rr_q][rd_ptr_q[rr_q]];
        credit_return_o = res_push_o ? (ntt_bfly_pkg::NUM_LANES'(1) << rr_q) : '0;
    end

    // Lane results land without back-pressure; credits bound the fill
    always_ff @(posedge hclk) begin
        for (int i = 0; i < ntt_bfly_pkg::NUM_LANES; i++) begin
            if (res_valid_i[i]) begin
                slot_q[i][wr_ptr_q[i]] <= res_i[i];
            end
        end
    end

    // ==================================================
    // Buffer pointers and round-robin
    // ==================================================
    always_ff @(posedge hclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            rr_q     <= '0;
            for (int i = 0; i < ntt_bfly_pkg::NUM_LANES; i++) begin
                cnt_q[i] <= 2'd0;
            end
        end else begin
            for (int i = 0; i < ntt_bfly_pkg::NUM_LANES; i++) begin
                if (res_valid_i[i]) wr_ptr_q[i] <= ~wr_ptr_q[i];
                if (credit_return_o[i]) rd_ptr_q[i] <= ~rd_ptr_q[i];
                cnt_q[i] <= cnt_q[i] + 2'(res_valid_i[i]) - 2'(credit_return_o[i]);
            end
            if (res_push_o) rr_q <= rr_q + 1'b1;
        end
    end

endmodule

/* verilog/ntt_bfly_top.sv */
`timescale 1ns/100ps

module ntt_bfly_top (
    input  logic                     hclk,
    input  logic                     rst_n_i,
    input  ntt_bfly_pkg::host_req_t  host_req_i,
    output ntt_bfly_pkg::host_resp_t host_resp_o
);

    logic job_valid, job_pop, busy, res_push, res_full;
    ntt_bfly_pkg::bfly_job_t job, issue_job;
    ntt_bfly_pkg::bfly_result_t res;
    logic [ntt_bfly_pkg::NUM_LANES-1:0] issue_valid, lane_valid, credit_return;
    ntt_bfly_pkg::bfly_result_t lane_res [ntt_bfly_pkg::NUM_LANES];

    ntt_host_regs ntt_host_regs_inst (
        .hclk        (hclk),
        .rst_n_i     (rst_n_i),
        .host_req_i  (host_req_i),
        .host_resp_o (host_resp_o),
        .job_pop_i   (job_pop),
        .job_valid_o (job_valid),
        .job_o       (job),
        .res_push_i  (res_push),
        .res_i       (res),
        .res_full_o  (res_full),
        .busy_i      (busy)
    );

    ntt_job_dispatch ntt_job_dispatch_inst (
        .hclk            (hclk),
        .rst_n_i         (rst_n_i),
        .job_valid_i     (job_valid),
        .job_i           (job),
        .job_pop_o       (job_pop),
        .issue_valid_o   (issue_valid),
        .issue_job_o     (issue_job),
        .credit_return_i (credit_return),
        .busy_o          (busy)
    );

    // ==================================================
    // Butterfly lanes
    // ==================================================
    for (genvar g = 0; g < ntt_bfly_pkg::NUM_LANES; g++) begin : g_lane
        ntt_bfly_lane ntt_bfly_lane_inst (
            .hclk          (hclk),
            .rst_n_i       (rst_n_i),
            .issue_valid_i (issue_valid[g]),
            .job_i         (issue_job),
            .res_valid_o   (lane_valid[g]),
            .res_o         (lane_res[g])
        );
    end

    ntt_result_collect ntt_result_collect_inst (
        .hclk            (hclk),
        .rst_n_i         (rst_n_i),
        .res_valid_i     (lane_valid),
        .res_i           (lane_res),
        .res_full_i      (res_full),
        .res_push_o      (res_push),
        .res_o           (res),
        .credit_return_o (credit_return)
    );

endmodule

/* sim/ntt_bfly_chk.sv */
`timescale 1ns/100ps

module ntt_bfly_chk (
    input logic                               hclk,
    input logic                               rst_n_i,
    input ntt_bfly_pkg::host_req_t            host_req_i,
    input ntt_bfly_pkg::host_resp_t           host_resp_i,
    input logic [ntt_bfly_pkg::NUM_LANES-1:0] issue_valid_i,
    input logic [1:0]                         credit_i [ntt_bfly_pkg::NUM_LANES]
);

    int fail_cnt = 0;
    logic rd_accept;
    logic job_write;

    always_comb begin
        rd_accept = host_req_i.valid && host_resp_i.ready && !host_req_i.write;
        job_write = host_req_i.valid && host_req_i.write
                    && host_req_i.addr == ntt_bfly_pkg::ADDR_JOB;
    end

    // ==================================================
    // Host port handshake
    // ==================================================
    rvalid_follows_read: assert property (@(posedge hclk) disable iff (!rst_n_i)
        host_resp_i.rvalid == $past(rd_accept))
    else begin
        $error("rvalid does not match an accepted read one cycle earlier");
        fail_cnt++;
    end

    // Only a job write may be held off
    ready_unless_job: assert property (@(posedge hclk) disable iff (!rst_n_i)
        !job_write |-> host_resp_i.ready)
    else begin
        $error("ready low for a request that is not a job write");
        fail_cnt++;
    end

    quiet_in_reset: assert property (@(posedge hclk)
        !rst_n_i |-> (!host_resp_i.rvalid && issue_valid_i == '0))
    else begin
        $error("rvalid or issue_valid active during reset");
        fail_cnt++;
    end

    // ==================================================
    // Lane credits
    // ==================================================
    for (genvar g = 0; g < ntt_bfly_pkg::NUM_LANES; g++) begin : g_credit
        credit_bounded: assert property (@(posedge hclk) disable iff (!rst_n_i)
            credit_i[g] <= 2'(ntt_bfly_pkg::LANE_CREDITS))
        else begin
            $error("lane %0d holds more credits than allowed", g);
            fail_cnt++;
        end
    end

endmodule

bind ntt_bfly_top ntt_bfly_chk ntt_bfly_chk_inst (
    .hclk          (hclk),
    .rst_n_i       (rst_n_i),
    .host_req_i    (host_req_i),
    .host_resp_i   (host_resp_o),
    .issue_valid_i (issue_valid),
    .credit_i      (ntt_job_dispatch_inst.credit_q)
);

/* sim/ntt_bfly_tb.sv */
`timescale 1ns/100ps

module ntt_bfly_tb;

    localparam int RANDOM_JOBS = 16;
    // Job FIFO, one slot per lane credit, result FIFO
    localparam int CAPACITY = 2 * ntt_bfly_pkg::FIFO_DEPTH
                              + ntt_bfly_pkg::NUM_LANES * ntt_bfly_pkg::LANE_CREDITS;
    // Job FIFO, issue, lane, collect
    localparam int JOB_TO_RESULT = 1 + 1 + ntt_bfly_pkg::LANE_LAT + 1;
    localparam int TOTAL_JOBS = 1 + 2 * RANDOM_JOBS + (CAPACITY + 1) + 16 + 1;
    localparam int WATCH_CYCLES = TOTAL_JOBS * 20 + 200;

    logic hclk;
    logic rst_n_i;
    ntt_bfly_pkg::host_req_t  host_req;
    ntt_bfly_pkg::host_resp_t host_resp;

    ntt_bfly_pkg::mode_t cur_mode;
    logic [31:0] lcg_state;
    logic [45:0] exp_q [$];
    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    int test_err_start;

    ntt_bfly_top ntt_bfly_top_inst (
        .hclk        (hclk),
        .rst_n_i     (rst_n_i),
        .host_req_i  (host_req),
        .host_resp_o (host_resp)
    );

    initial hclk = 1'b0;
    always #2 hclk = ~hclk;

    // ==================================================
    // Stimulus and reference model
    // ==================================================
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected {a, b} straight from the butterfly formulas
    function automatic logic [45:0] butterfly_ref(input ntt_bfly_pkg::mode_t m,
                                                  input logic [22:0] u, v, w);
        longint unsigned q, uu, vv, ww, t, a, b;
        q  = ntt_bfly_pkg::Q;
        uu = u;
        vv = v;
        ww = w;
        if (m == ntt_bfly_pkg::MODE_CT) begin
            t = (ww * vv) % q;
            a = (uu + t) % q;
            b = (uu + q - t) % q;
        end else begin
            a = (uu + vv) % q;
            b = (((uu + q - vv) % q) * ww) % q;
        end
        return {a[22:0], b[22:0]};
    endfunction

    task automatic next_coef(output logic [22:0] c);
        lcg_state = lcg_next(lcg_state);
        c = 23'(lcg_state % ntt_bfly_pkg::Q);
    endtask

    task automatic expect_eq(input string what, input logic [71:0] exp, input logic [71:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR @ %0t ns: %s expected %0h, got %0h", $time, what, exp, got);
        end
    endtask

    // ==================================================
    // Host port access, from one falling edge to the next
    // ==================================================
    task automatic write_reg(input logic [1:0] addr, input ntt_bfly_pkg::bus_word_u data,
                             input int max_wait, output bit accepted);
        bit rdy;
        int waited;
        waited   = 0;
        accepted = 1'b0;
        host_req.valid = 1'b1;
        host_req.write = 1'b1;
        host_req.addr  = addr;
        host_req.wdata = data;
        // Hold the request while ready is low
        while (!accepted && waited <= max_wait) begin
            #1;
            rdy = host_resp.ready;
            @(negedge hclk);
            if (rdy) accepted = 1'b1;
            else waited++;
        end
        host_req.valid = 1'b0;
    endtask

    task automatic read_reg(input logic [1:0] addr, output logic [71:0] data);
        host_req.valid = 1'b1;
        host_req.write = 1'b0;
        host_req.addr  = addr;
        host_req.wdata = '0;
        @(negedge hclk);
        host_req.valid = 1'b0;
        expect_eq("read response valid", 72'd1, 72'(host_resp.rvalid));
        data = host_resp.rdata;
    endtask

    task automatic set_mode(input ntt_bfly_pkg::mode_t m);
        ntt_bfly_pkg::bus_word_u word;
        bit ok;
        word = '0;
        word.ctrl.mode = m;
        write_reg(ntt_bfly_pkg::ADDR_CTRL, word, 100, ok);
        cur_mode = m;
    endtask

    task automatic send_job(input logic [22:0] u, v, w, input int max_wait,
                            output bit accepted);
        ntt_bfly_pkg::bus_word_u word;
        word = '0;
        word.op.u = u;
        word.op.v = v;
        word.op.w = w;
        write_reg(ntt_bfly_pkg::ADDR_JOB, word, max_wait, accepted);
        if (accepted) exp_q.push_back(butterfly_ref(cur_mode, u, v, w));
    endtask

    task automatic random_job(input int max_wait, output bit accepted);
        logic [22:0] u, v, w;
        next_coef(u);
        next_coef(v);
        next_coef(w);
        send_job(u, v, w, max_wait, accepted);
    endtask

    task automatic check_result(input logic [71:0] data);
        logic [45:0] exp;
        checks++;
        assert (exp_q.size() != 0) else begin
            errors++;
            $display("A result came back although no job was outstanding at %0t ns", $time);
        end
        if (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            expect_eq("result a", 72'(exp[45:23]), 72'(data[22:0]));
            expect_eq("result b", 72'(exp[22:0]), 72'(data[46:24]));
        end
    endtask

    task automatic drain_results();
        logic [71:0] data;
        while (exp_q.size() != 0) begin
            read_reg(ntt_bfly_pkg::ADDR_RESULT, data);
            if (data[71]) check_result(data);
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors != test_err_start) tests_failed++;
        $display("%-14s finished with %0d errors", name, errors - test_err_start);
        test_err_start = errors;
    endtask

    // ==================================================
    // Tests
    // ==================================================
    task automatic check_reset_state();
        logic [71:0] data;
        expect_eq("ready after reset", 72'd1, 72'(host_resp.ready));
        expect_eq("rvalid after reset", 72'd0, 72'(host_resp.rvalid));
        read_reg(ntt_bfly_pkg::ADDR_STATUS, data);
        expect_eq("status after reset", 72'd0, data);
        read_reg(ntt_bfly_pkg::ADDR_CTRL, data);
        expect_eq("mode after reset", 72'(ntt_bfly_pkg::MODE_CT), data);
    endtask

    task automatic ct_random_jobs();
        logic [71:0] data;
        bit ok;
        set_mode(ntt_bfly_pkg::MODE_CT);
        random_job(100, ok);
        // STATUS one cycle before the result is due, then RESULT right on time
        repeat (JOB_TO_RESULT - 2) @(negedge hclk);
        read_reg(ntt_bfly_pkg::ADDR_STATUS, data);
        expect_eq("result count before due", 72'd0, 72'(data[7:4]));
        read_reg(ntt_bfly_pkg::ADDR_RESULT, data);
        expect_eq("result present when due", 72'd1, 72'(data[71]));
        if (data[71]) check_result(data);
        repeat (RANDOM_JOBS) random_job(100, ok);
        drain_results();
    endtask

    task automatic gs_random_jobs();
        bit ok;
        set_mode(ntt_bfly_pkg::MODE_GS);
        repeat (RANDOM_JOBS) random_job(100, ok);
        drain_results();
    endtask

    task automatic backpressure_fill();
        bit ok;
        bit refused;
        int taken;
        refused = 1'b0;
        taken   = 0;
        set_mode(ntt_bfly_pkg::MODE_CT);
        // One write more than the design holds, and no reads yet
        for (int i = 0; i <= CAPACITY; i++) begin
            random_job(8, ok);
            if (ok) taken++;
            else refused = 1'b1;
        end
        expect_eq("jobs taken before ready dropped", 72'(CAPACITY), 72'(taken));
        expect_eq("last write held off", 72'd1, 72'(refused));
        drain_results();
    endtask

    task automatic edge_operands();
        logic [22:0] vals [2];
        logic [22:0] twid [2];
        bit ok;
        vals[0] = 23'd0;
        vals[1] = ntt_bfly_pkg::Q - 23'd1;
        twid[0] = 23'd1;
        twid[1] = ntt_bfly_pkg::Q - 23'd1;
        for (int m = 0; m < 2; m++) begin
            set_mode(ntt_bfly_pkg::mode_t'(m));
            for (int iu = 0; iu < 2; iu++) begin
                for (int iv = 0; iv < 2; iv++) begin
                    for (int iw = 0; iw < 2; iw++) begin
                        send_job(vals[iu], vals[iv], twid[iw], 100, ok);
                    end
                end
            end
            drain_results();
        end
    endtask

    task automatic empty_result_read();
        logic [71:0] data;
        bit ok;
        read_reg(ntt_bfly_pkg::ADDR_RESULT, data);
        expect_eq("present flag on empty read", 72'd0, 72'(data[71]));
        random_job(100, ok);
        drain_results();
    endtask

    // ==================================================
    // Main sequence and watchdog
    // ==================================================
    initial begin
        host_req       = '0;
        rst_n_i        = 1'b0;
        cur_mode       = ntt_bfly_pkg::MODE_CT;
        lcg_state      = 32'h3328_bdcf;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        test_err_start = 0;
        repeat (5) @(posedge hclk);
        @(negedge hclk);
        rst_n_i = 1'b1;
        @(negedge hclk);

        check_reset_state();
        report_test("after_reset");
        ct_random_jobs();
        report_test("ct_mode");
        gs_random_jobs();
        report_test("gs_mode");
        backpressure_fill();
        report_test("backpressure");
        edge_operands();
        report_test("edge_values");
        empty_result_read();
        report_test("empty_read");

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, checks, errors,
                 ntt_bfly_top_inst.ntt_bfly_chk_inst.fail_cnt);
        if (errors == 0 && ntt_bfly_top_inst.ntt_bfly_chk_inst.fail_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCH_CYCLES) @(posedge hclk);
        $display("Timeout: the tests did not finish within %0d clock cycles", WATCH_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* build.f */
verilog/ntt_bfly_pkg.sv
verilog/ntt_mod_mult.sv
verilog/ntt_bfly_lane.sv
verilog/ntt_host_regs.sv
verilog/ntt_job_dispatch.sv
verilog/ntt_result_collect.sv
verilog/ntt_bfly_top.sv
sim/ntt_bfly_chk.sv
sim/ntt_bfly_tb.sv
